/* src/irTx_defines.svh */
`ifndef IR_TX_DEFINES_SVH
`define IR_TX_DEFINES_SVH

// Code memory depth as address bits, 256 bytes
`define IR_MEM_ADR_WIDTH 8

// Clock, carrier-cycle and entry width
`define IR_CNT_WIDTH 16

// Host register map
`define IR_REG_CTRL     3'd0 // Bit0 start, bit1 stop, bit2 int clear
`define IR_REG_DUTY     3'd1
`define IR_REG_CYCLE    3'd2
`define IR_REG_RPT      3'd3 // Bit7 infinite repeat
`define IR_REG_CODE_END 3'd4
`define IR_REG_MEM_PTR  3'd5
`define IR_REG_MEM_DATA 3'd6 // Auto-increments the pointer

`endif

/* src/irTxCfgPkg.sv */
`default_nettype none
`include "irTx_defines.svh"

package irTxCfgPkg;

	typedef enum logic [2:0] {
		REG_CTRL     = `IR_REG_CTRL,
		REG_DUTY     = `IR_REG_DUTY,
		REG_CYCLE    = `IR_REG_CYCLE,
		REG_RPT      = `IR_REG_RPT,
		REG_CODE_END = `IR_REG_CODE_END,
		REG_MEM_PTR  = `IR_REG_MEM_PTR,
		REG_MEM_DATA = `IR_REG_MEM_DATA
	} irRegAdr_e;

	// One host write, single cycle
	typedef struct packed {
		logic                     we;
		irRegAdr_e                adr;
		logic [15:0]              data;
	} regWr_t;

	typedef struct packed {
		logic [`IR_CNT_WIDTH-1:0]     dutyLen;    // Carrier high time in clocks
		logic [`IR_CNT_WIDTH-1:0]     cycLen;     // Carrier period in clocks
		logic [6:0]                   rptLen;     // Extra frames
		logic                         rptInf;     // Repeat until stop
		logic [`IR_MEM_ADR_WIDTH-1:0] codeEndAdr; // Last code byte
	} irTxCfg_t;

	typedef struct packed {
		logic txOn;
		logic intFlag;
	} irStatus_t;

endpackage

`default_nettype wire

/* src/irTxCtrlPkg.sv */
`default_nettype none

package irTxCtrlPkg;

	// Transmit FSM states
	typedef enum logic [1:0] {
		WAIT_ST  = 2'd0,
		BURST_ST = 2'd1, // Carrier on
		GAP_ST   = 2'd2  // Output held low
	} irTxState_e;

	// Counter steering from the controller
	typedef struct packed {
		logic clkEn;   // Clock-in-period counter runs
		logic clkSet1; // Realign period at carrier begin
		logic cycEn;   // One carrier period done
		logic cycSet1; // New entry starts
		logic rptEn;   // Frame repeated
		logic rptClr;  // Fresh transfer
	} irCntCtl_t;

	typedef struct packed {
		logic rcs;
		logic re;
		logic adrRst;
	} irMemRd_t;

endpackage

`default_nettype wire

/* src/irTxRegs.sv */
`timescale 1ns/1ns
`default_nettype none
`include "irTx_defines.svh"

module irTxRegs import irTxCfgPkg::*; (
	input  wire logic                          CLK_i,
	input  wire logic                          RST_i,
	input  wire regWr_t                        wr_i,
	input  wire logic                          txOn_i,     // Transfer running
	input  wire logic                          txEnd_i,    // One-cycle end pulse
	output irTxCfg_t                           cfg_o,
	output logic                               startReq_o,
	output logic                               stopReq_o,
	output logic                               memWrEn_o,
	output logic [`IR_MEM_ADR_WIDTH-1:0]       memWrAdr_o,
	output logic [7:0]                         memWrData_o,
	output logic                               intFlag_o
);

	logic [`IR_MEM_ADR_WIDTH-1:0] memPtr; // Host write pointer
	logic wrCtrl;
	logic intClrP, intClr;                // Interrupt clear stages

	assign wrCtrl      = wr_i.we && (wr_i.adr == REG_CTRL);
	assign memWrEn_o   = wr_i.we && (wr_i.adr == REG_MEM_DATA);
	assign memWrAdr_o  = memPtr;
	assign memWrData_o = wr_i.data[7:0]; // Low byte only

	//**************************************************************************
	// Configuration registers
	//**************************************************************************
	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i) begin
			cfg_o <= '0;
		end else if (wr_i.we) begin
			case (wr_i.adr)
				REG_DUTY:     cfg_o.dutyLen    <= wr_i.data;
				REG_CYCLE:    cfg_o.cycLen     <= wr_i.data;
				REG_RPT: begin
					cfg_o.rptLen <= wr_i.data[6:0];
					cfg_o.rptInf <= wr_i.data[7];
				end
				REG_CODE_END: cfg_o.codeEndAdr <= wr_i.data[`IR_MEM_ADR_WIDTH-1:0];
				default: ;
			endcase
		end
	end

	// Pointer load, or step after each data byte
	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i) begin
			memPtr <= '0;
		end else if (wr_i.we && (wr_i.adr == REG_MEM_PTR)) begin
			memPtr <= wr_i.data[`IR_MEM_ADR_WIDTH-1:0];
		end else if (memWrEn_o) begin
			memPtr <= memPtr + 1'b1;
		end
	end

	//**************************************************************************
	// Request flags, cleared by the controller
	//**************************************************************************
	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i) begin
			startReq_o <= 1'b0;
			stopReq_o  <= 1'b0;
		end else begin
			if (txOn_i)
				startReq_o <= 1'b0; // Taken by the FSM
			else if (wrCtrl && wr_i.data[0])
				startReq_o <= 1'b1;
			if (!txOn_i)
				stopReq_o <= 1'b0;  // Nothing left to stop
			else if (wrCtrl && wr_i.data[1])
				stopReq_o <= 1'b1;
		end
	end

	// Interrupt flag with staged clear
	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i) begin
			intClrP   <= 1'b0;
			intClr    <= 1'b0;
			intFlag_o <= 1'b0;
		end else begin
			intClrP <= wrCtrl && wr_i.data[2];
			intClr  <= intClrP;
			if (txEnd_i)
				intFlag_o <= 1'b1; // Set wins over clear
			else if (intClr)
				intFlag_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/irCodeMem.sv */
`timescale 1ns/1ns
`default_nettype none
`include "irTx_defines.svh"

module irCodeMem import irTxCtrlPkg::*; (
	input  wire logic                          CLK_i,
	input  wire logic                          RST_i,
	input  wire logic                          wrEn_i,
	input  wire logic [`IR_MEM_ADR_WIDTH-1:0]  wrAdr_i,
	input  wire logic [7:0]                    wrData_i,
	input  wire irMemRd_t                      rd_i,
	output logic [7:0]                         rdData_o,  // One cycle after re
	output logic [`IR_MEM_ADR_WIDTH-1:0]       rdAdr_o
);

	localparam int MEM_DEPTH = 1 << `IR_MEM_ADR_WIDTH;

	logic [7:0] mem [0:MEM_DEPTH-1]; // Code table, LSB first
	logic rdHit;

	assign rdHit = rd_i.rcs && rd_i.re;

	// Host side byte write
	always_ff @(posedge CLK_i) begin
		if (wrEn_i)
			mem[wrAdr_i] <= wrData_i;
	end

	// Registered read port
	always_ff @(posedge CLK_i) begin
		if (rdHit)
			rdData_o <= mem[rdAdr_o];
	end

	//**************************************************************************
	// Sequential fetch address
	//**************************************************************************
	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i) begin
			rdAdr_o <= '0;
		end else if (rd_i.adrRst) begin
			rdAdr_o <= '0;    // Frame end, back to first entry
		end else if (rdHit) begin
			rdAdr_o <= rdAdr_o + 1'b1;
		end
	end

	// Read strobe only inside a selected transfer
	reNeedsRcs: assert property (@(posedge CLK_i) disable iff (RST_i)
		!(rd_i.re && !rd_i.rcs))
		else $error("code memory read without chip select");

endmodule

`default_nettype wire

/* src/irTxCounters.sv */
`timescale 1ns/1ns
`default_nettype none
`include "irTx_defines.svh"

module irTxCounters import irTxCtrlPkg::*; (
	input  wire logic                          CLK_i,
	input  wire logic                          RST_i,
	input  wire irCntCtl_t                     ctl_i,
	input  wire logic [`IR_CNT_WIDTH-1:0]      cycLen_i,
	output logic [`IR_CNT_WIDTH-1:0]           clkCnt_o,  // 1 .. cycLen
	output logic [`IR_CNT_WIDTH-1:0]           cycCnt_o,  // Carrier periods in entry
	output logic [6:0]                         rptCnt_o   // Frames already sent
);

	localparam logic [`IR_CNT_WIDTH-1:0] CNT_ONE = 1;

	// Clock in carrier period, parked at 0 while idle
	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i)
			clkCnt_o <= '0;
		else if (!ctl_i.clkEn)
			clkCnt_o <= '0;
		else if (ctl_i.clkSet1 || (clkCnt_o >= cycLen_i))
			clkCnt_o <= CNT_ONE; // Wrap at period end
		else
			clkCnt_o <= clkCnt_o + 1'b1;
	end

	// Carrier cycles of the current entry
	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i)
			cycCnt_o <= '0;
		else if (ctl_i.cycSet1)
			cycCnt_o <= CNT_ONE;
		else if (ctl_i.cycEn)
			cycCnt_o <= cycCnt_o + 1'b1;
	end

	// Frame repeats
	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i)
			rptCnt_o <= '0;
		else if (ctl_i.rptClr)
			rptCnt_o <= '0;
		else if (ctl_i.rptEn)
			rptCnt_o <= rptCnt_o + 1'b1;
	end

endmodule

`default_nettype wire

/* src/irTxCtrl.sv */
`timescale 1ns/1ns
`default_nettype none
`include "irTx_defines.svh"

module irTxCtrl import irTxCfgPkg::*, irTxCtrlPkg::*; (
	input  wire logic                          CLK_i,
	input  wire logic                          RST_i,
	input  wire irTxCfg_t                      cfg_i,
	input  wire logic                          startReq_i,
	input  wire logic                          stopReq_i,
	input  wire logic [`IR_CNT_WIDTH-1:0]      clkCnt_i,
	input  wire logic [`IR_CNT_WIDTH-1:0]      cycCnt_i,
	input  wire logic [6:0]                    rptCnt_i,
	input  wire logic [7:0]                    memData_i,
	input  wire logic [`IR_MEM_ADR_WIDTH-1:0]  memAdr_i,
	output logic                               txOn_o,
	output logic                               txEnd_o,
	output logic                               txd_o,
	output irCntCtl_t                          cnt_o,
	output irMemRd_t                           mem_o
);

	irTxState_e state, nState;
	logic crrBgn, clkEn, memReD, lastCode;
	logic [7:0] memLsb;                    // Low byte of fetched entry
	logic cycSet1, nCycSet1, rptInc, nRptInc;
	logic memRe, nMemRe, nTxEnd;
	logic dutyFull, clkFull, cycFull, codeDone, rptDone, frameFin, startGo;

	assign dutyFull = (clkCnt_i == cfg_i.dutyLen);
	assign clkFull  = (clkCnt_i == cfg_i.cycLen);   // Carrier period end
	assign cycFull  = (cycCnt_i == {memData_i, memLsb});
	assign codeDone = clkFull && cycFull;           // Entry exhausted
	assign rptDone  = !cfg_i.rptInf && (rptCnt_i == cfg_i.rptLen);
	assign frameFin = lastCode && (rptDone || stopReq_i);
	assign startGo  = startReq_i && txOn_o && (state == WAIT_ST);

	assign cnt_o.clkEn   = clkEn;
	assign cnt_o.clkSet1 = crrBgn;
	assign cnt_o.cycEn   = (state != WAIT_ST) && clkFull;
	assign cnt_o.cycSet1 = cycSet1;
	assign cnt_o.rptEn   = rptInc;
	assign cnt_o.rptClr  = startReq_i && !txOn_o;
	assign mem_o.rcs     = txOn_o;
	assign mem_o.re      = (memRe || memReD) && txOn_o; // Two reads per entry
	assign mem_o.adrRst  = lastCode && codeDone;

	//**************************************************************************
	// Transfer flags and fetch bookkeeping
	//**************************************************************************
	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i) begin
			txOn_o   <= 1'b0;
			clkEn    <= 1'b0;
			crrBgn   <= 1'b0;
			memReD   <= 1'b0;
			lastCode <= 1'b0;
		end else begin
			if (startReq_i)
				txOn_o <= 1'b1;
			else if (txEnd_o)
				txOn_o <= 1'b0;
			if (txEnd_o)
				clkEn <= 1'b0;
			else if (startGo)
				clkEn <= 1'b1;
			crrBgn <= startGo; // First pulse of the transfer
			memReD <= memRe;
			if (state != GAP_ST)
				lastCode <= 1'b0;
			else if (memAdr_i == cfg_i.codeEndAdr)
				lastCode <= 1'b1; // High byte of final gap fetched
		end
	end

	always_ff @(posedge CLK_i) begin
		if (memReD)
			memLsb <= memData_i;
	end

	// Carrier shaping
	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i)
			txd_o <= 1'b0;
		else if (dutyFull)
			txd_o <= 1'b0;
		else if (crrBgn || ((state == BURST_ST) && clkFull && !cycFull) ||
				((state == GAP_ST) && codeDone && !frameFin))
			txd_o <= 1'b1;
	end

	//**************************************************************************
	// FSM
	//**************************************************************************
	always_comb begin
		nState   = state;
		nCycSet1 = 1'b0;
		nRptInc  = 1'b0;
		nMemRe   = 1'b0;
		nTxEnd   = 1'b0;
		case (state)
			WAIT_ST: if (startGo) begin
				nCycSet1 = 1'b1;
				nMemRe   = 1'b1;
				nState   = BURST_ST;
			end
			BURST_ST: if (codeDone) begin
				nCycSet1 = 1'b1;
				nMemRe   = 1'b1; // Fetch gap entry
				nState   = GAP_ST;
			end
			GAP_ST: if (codeDone) begin
				if (frameFin) begin
					nTxEnd = 1'b1;
					nState = WAIT_ST;
				end else begin
					nCycSet1 = 1'b1;
					nMemRe   = 1'b1;
					nRptInc  = lastCode; // Wrap into next frame
					nState   = BURST_ST;
				end
			end
			default: nState = WAIT_ST;
		endcase
	end

	always_ff @(posedge CLK_i or posedge RST_i) begin
		if (RST_i) begin
			state   <= WAIT_ST;
			cycSet1 <= 1'b0;
			rptInc  <= 1'b0;
			memRe   <= 1'b0;
			txEnd_o <= 1'b0;
		end else begin
			state   <= nState;
			cycSet1 <= nCycSet1;
			rptInc  <= nRptInc;
			memRe   <= nMemRe;
			txEnd_o <= nTxEnd;
		end
	end

	stateLegal: assert property (@(posedge CLK_i) disable iff (RST_i)
		state inside {WAIT_ST, BURST_ST, GAP_ST});
	txdInBurst: assert property (@(posedge CLK_i) disable iff (RST_i)
		txd_o |-> (state == BURST_ST));
	txEndPulse: assert property (@(posedge CLK_i) disable iff (RST_i)
		txEnd_o |=> !txEnd_o);

endmodule

`default_nettype wire

/* src/irTxTop.sv */
`timescale 1ns/1ns
`default_nettype none
`include "irTx_defines.svh"

module irTxTop import irTxCfgPkg::*, irTxCtrlPkg::*; (
	input  wire logic      CLK_i,
	input  wire logic      RST_i,
	input  wire regWr_t    wr_i,     // Host register port
	output logic           TXD_o,
	output logic           INT_o,
	output logic           TX_ON_o,
	output irStatus_t      status_o
);

	irTxCfg_t  cfg;
	irCntCtl_t cntCtl;
	irMemRd_t  memRd;
	logic startReq, stopReq, intFlag, txOn, txEnd, txd;
	logic memWrEn;
	logic [`IR_MEM_ADR_WIDTH-1:0] memWrAdr, memRdAdr;
	logic [7:0] memWrData, memRdData;
	logic [`IR_CNT_WIDTH-1:0] clkCnt, cycCnt;
	logic [6:0] rptCnt;

	assign TXD_o            = txd;
	assign INT_o            = intFlag;
	assign TX_ON_o          = txOn;
	assign status_o.txOn    = txOn;
	assign status_o.intFlag = intFlag;

	irTxRegs uRegs (.CLK_i, .RST_i, .wr_i, .txOn_i(txOn), .txEnd_i(txEnd),
		.cfg_o(cfg), .startReq_o(startReq), .stopReq_o(stopReq), .memWrEn_o(memWrEn),
		.memWrAdr_o(memWrAdr), .memWrData_o(memWrData), .intFlag_o(intFlag));

	irCodeMem uMem (.CLK_i, .RST_i, .wrEn_i(memWrEn), .wrAdr_i(memWrAdr),
		.wrData_i(memWrData), .rd_i(memRd), .rdData_o(memRdData), .rdAdr_o(memRdAdr));

	irTxCounters uCnt (.CLK_i, .RST_i, .ctl_i(cntCtl), .cycLen_i(cfg.cycLen),
		.clkCnt_o(clkCnt), .cycCnt_o(cycCnt), .rptCnt_o(rptCnt));

	irTxCtrl uCtrl (.CLK_i, .RST_i, .cfg_i(cfg), .startReq_i(startReq),
		.stopReq_i(stopReq), .clkCnt_i(clkCnt), .cycCnt_i(cycCnt), .rptCnt_i(rptCnt),
		.memData_i(memRdData), .memAdr_i(memRdAdr), .txOn_o(txOn), .txEnd_o(txEnd),
		.txd_o(txd), .cnt_o(cntCtl), .mem_o(memRd));

endmodule

`default_nettype wire

/* verification/irTxTb.sv */
`timescale 1ns/1ns
`default_nettype none

module irTxTb import irTxCfgPkg::*; ();

	// One measured or expected TXD feature
	typedef struct packed {
		logic        isGap; // Low run between bursts
		logic [15:0] val;   // Pulse count or low clocks
	} txdItem_t;

	logic clk, rst;
	regWr_t wr;
	logic txd, intr, txOn;
	irStatus_t status;

	integer seed;
	int errCnt = 0;
	int chkCnt = 0;
	int pulseTotal = 0;                // Rising edges seen, never cleared
	longint wdLimit;
	bit wdArmed = 1'b0;
	string curTest = "reset";
	logic [15:0] curDuty = 16'd1;
	logic [15:0] curCyc = 16'd2;

	logic [15:0] codeTbl [0:2][0:7];   // Even burst, odd gap
	int codeLen [0:2] = '{4, 6, 4};
	logic [15:0] tDuty [0:2] = '{16'd2, 16'd3, 16'd1};
	logic [15:0] tCyc [0:2] = '{16'd5, 16'd8, 16'd4};
	int tFrames [0:2] = '{1, 3, 3};   // Stop run budgets 3 frames

	txdItem_t expQ [$];
	txdItem_t measQ [$];

	// Measurer state
	logic [15:0] highLen, lowLen, burstPulses;
	logic inGap, txdPrev;

	irTxTop uut (.CLK_i(clk), .RST_i(rst), .wr_i(wr), .TXD_o(txd), .INT_o(intr),
		.TX_ON_o(txOn), .status_o(status));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	//**************************************************************************
	// Checks and host access
	//**************************************************************************
	task automatic checkCount(input string what, input logic [15:0] exp,
			input logic [15:0] act, input int tol);
		int diff;
		chkCnt++;
		diff = int'(act) - int'(exp);
		if (diff > tol || diff < -tol) begin
			errCnt++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", what, exp, act);
		end
	endtask

	task automatic checkStatus(input string what, input irStatus_t exp, input irStatus_t act);
		chkCnt++;
		if (exp !== act) begin
			errCnt++;
			$display("CHECK FAILED %s: expected %b, actual %b", what, exp, act);
		end
	endtask

	// Single-cycle write, driven between rising edges
	task automatic writeReg(input irRegAdr_e adr, input logic [15:0] data);
		@(negedge clk);
		wr.we   = 1'b1;
		wr.adr  = adr;
		wr.data = data;
		@(negedge clk);
		wr.we   = 1'b0;
	endtask

	function automatic int framePulses(input int t);
		int sum;
		sum = 0;
		for (int e = 0; e < codeLen[t]; e += 2)
			sum += codeTbl[t][e];
		return sum;
	endfunction

	// Reference waveform model, final gap of the run is open ended
	function automatic void buildExpected(input int t, input int frames,
			input logic [15:0] duty, input logic [15:0] cyc);
		txdItem_t item;
		expQ.delete();
		for (int f = 0; f < frames; f++) begin
			for (int e = 0; e < codeLen[t]; e++) begin
				if (f == frames - 1 && e == codeLen[t] - 1)
					break;
				item.isGap = e[0];
				// Gap keeps the idle tail of the last pulse
				item.val = e[0] ? codeTbl[t][e] * cyc + cyc - duty : codeTbl[t][e];
				expQ.push_back(item);
			end
		end
	endfunction

	//**************************************************************************
	// TXD measurer and compare
	//**************************************************************************
	always @(negedge clk) begin
		txdItem_t item;
		if (!txOn) begin // Idle, start over
			burstPulses = '0;
			lowLen      = '0;
			highLen     = '0;
			inGap       = 1'b0;
		end else if (txd) begin
			if (!txdPrev) begin
				if (inGap) begin
					item.isGap = 1'b1;
					item.val   = lowLen;
					measQ.push_back(item);
				end
				inGap = 1'b0;
				burstPulses++;
				pulseTotal++;
				highLen = '0;
			end
			highLen++;
		end else begin
			if (txdPrev) begin
				checkCount({curTest, " pulse high"}, curDuty, highLen, 0);
				lowLen = '0;
			end
			lowLen++;
			if (!inGap && burstPulses != 0 && lowLen > curCyc - curDuty) begin
				item.isGap  = 1'b0; // Longer than a carrier off time
				item.val    = burstPulses;
				measQ.push_back(item);
				burstPulses = '0;
				inGap       = 1'b1;
			end
		end
		txdPrev = txd;
	end

	always @(posedge clk) begin
		txdItem_t got, want;
		while (measQ.size() != 0) begin
			got = measQ.pop_front();
			if (expQ.size() == 0) begin
				errCnt++;
				$display("%s: TXD shows more bursts or gaps than the table holds", curTest);
			end else begin
				want = expQ.pop_front();
				if (want.isGap != got.isGap) begin
					errCnt++;
					$display("%s: burst and gap order on TXD is wrong", curTest);
				end else begin
					checkCount({curTest, got.isGap ? " gap" : " burst"}, want.val, got.val,
						got.isGap ? 1 : 0);
				end
			end
		end
	end

	//**************************************************************************
	// One transfer from table load to interrupt clear
	//**************************************************************************
	task automatic runTransfer(input string name, input int t, input logic [7:0] rpt,
			input bit useStop);
		int startTotal, frameTotal, n;
		curTest    = name;
		curDuty    = tDuty[t];
		curCyc     = tCyc[t];
		frameTotal = framePulses(t);
		buildExpected(t, tFrames[t], tDuty[t], tCyc[t]);
		writeReg(REG_MEM_PTR, 16'd0);
		for (int i = 0; i < codeLen[t]; i++) begin
			writeReg(REG_MEM_DATA, {8'h00, codeTbl[t][i][7:0]}); // LSB first
			writeReg(REG_MEM_DATA, {8'h00, codeTbl[t][i][15:8]});
		end
		writeReg(REG_DUTY, tDuty[t]);
		writeReg(REG_CYCLE, tCyc[t]);
		writeReg(REG_RPT, {8'h00, rpt});
		writeReg(REG_CODE_END, 16'(2 * codeLen[t] - 1));
		startTotal = pulseTotal;
		writeReg(REG_CTRL, 16'h0001);
		while (!txOn)
			@(negedge clk);
		if (useStop) begin
			while (pulseTotal - startTotal <= frameTotal) // Into frame two
				@(negedge clk);
			writeReg(REG_CTRL, 16'h0002);
		end
		while (txOn)
			@(negedge clk);
		repeat (2) @(negedge clk);
		n = pulseTotal - startTotal;
		if (useStop) begin
			checkCount({name, " frame boundary"}, 16'd0, 16'(n % frameTotal), 0);
			checkCount({name, " frames sent"}, 16'd2, 16'(n / frameTotal), 0);
		end else begin
			checkCount({name, " pulse total"}, 16'(tFrames[t] * frameTotal), 16'(n), 0);
			if (expQ.size() != 0) begin
				errCnt++;
				$display("%s: %0d expected bursts or gaps never appeared", name, expQ.size());
			end
		end
		expQ.delete();
		checkStatus({name, " end status"}, '{txOn: 1'b0, intFlag: 1'b1}, status);
		repeat (4) @(negedge clk);
		checkStatus({name, " interrupt held"}, '{txOn: 1'b0, intFlag: 1'b1}, status);
		writeReg(REG_CTRL, 16'h0004);
		n = 0;
		while (intr && n < 3) begin
			@(negedge clk);
			n++;
		end
		if (intr) begin
			errCnt++;
			$display("%s: interrupt still set 3 cycles after the clear write", name);
		end
		checkStatus({name, " status after clear"}, '0, status);
	endtask

	initial begin
		rst  = 1'b1;
		wr   = '0;
		seed = 32'hd9e5;
		wdLimit = 3000; // Register writes and settling
		for (int t = 0; t < 3; t++) begin
			for (int e = 0; e < codeLen[t]; e++)
				codeTbl[t][e] = 16'(1 + ($unsigned($random(seed)) % 6));
		end
		for (int t = 0; t < 3; t++) begin
			longint sum;
			sum = 2;
			for (int e = 0; e < codeLen[t]; e++)
				sum += codeTbl[t][e];
			wdLimit += tFrames[t] * sum * tCyc[t] * 8 + 2 * codeLen[t] * 32;
		end
		wdArmed = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		@(negedge clk);
		checkStatus("reset status", '0, status);
		checkStatus("reset pins", '0, irStatus_t'({txOn, intr}));
		checkCount("reset TXD", 16'd0, {15'd0, txd}, 0);

		runTransfer("single frame", 0, 8'h00, 1'b0);
		runTransfer("repeat", 1, 8'h02, 1'b0); // Three frames
		runTransfer("stop", 2, 8'h80, 1'b1);   // Infinite until stop

		repeat (4) @(negedge clk);
		$display("Checks run: %0d, failed: %0d", chkCnt, errCnt);
		if (errCnt == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Bound on total run time
	initial begin
		wait (wdArmed);
		#(wdLimit);
		$display("Watchdog expired after %0d ns, a transfer never finished", wdLimit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+src
src/irTxCfgPkg.sv
src/irTxCtrlPkg.sv
src/irTxRegs.sv
src/irCodeMem.sv
src/irTxCounters.sv
src/irTxCtrl.sv
src/irTxTop.sv
verification/irTxTb.sv
